//--- Bender.yml
package:
  name: entropy_out

sources:
  - files:
      - design/bitpack_pkg.sv
      - design/stream_pkg.sv
      - design/code_emitter.sv
      - design/bit_packer.sv
      - design/word_fifo.sv
      - design/byte_stuffer.sv
      - design/entropy_out_top.sv
  - target: simulation
    files:
      - verification/tb_entropy_out.sv

//--- all.f
design/bitpack_pkg.sv
design/stream_pkg.sv
design/code_emitter.sv
design/bit_packer.sv
design/word_fifo.sv
design/byte_stuffer.sv
design/entropy_out_top.sv
verification/tb_entropy_out.sv

//--- design/bit_packer.sv
// packer of MSB aligned codes (1..27 bits) into 32-bit words
// three-stage barrel shifter, byte shift, two-bit shift, then
// one-bit shift merged into the hold register under a position mask
// partial word with rounded-up byte count on flush
`timescale 1ns/1ps

module bit_packer (
    input  logic                           xclk,
    input  logic                           rst,
    input  logic [bitpack_pkg::code_w-1:0] din,        // MSB aligned, low bits clear
    input  logic [bitpack_pkg::len_w-1:0]  dlen,
    input  logic                           ds,
    input  logic                           flush_in,   // after the last ds of a block
    output logic [bitpack_pkg::word_w-1:0] d_out,
    output logic [bitpack_pkg::cnt_w-1:0]  bytes_out,  // 0 means 4, valid with dv
    output logic                           dv,
    output logic                           flush_out
);

    localparam int d1_w = bitpack_pkg::code_w + bitpack_pkg::word_w - 8;   // after byte shift
    localparam int d2_w = d1_w + 6;                                        // after 2-bit shift
    localparam int d3_w = d2_w + 1;                                        // after 1-bit shift
    localparam int ov_w = d3_w - bitpack_pkg::word_w;                      // spill into next word

    logic [bitpack_pkg::len_w-1:0] pos;       // running bit position in the word
    logic [bitpack_pkg::len_w:0]   pos_sum;   // msb is the word-complete carry

    logic [d1_w-1:0]                data1;
    logic [bitpack_pkg::len_w-1:0]  p1;       // position before this code
    logic [bitpack_pkg::len_w-1:0]  n1;       // position after this code
    logic                           c1;

    logic [d2_w-1:0]                data2;
    logic [bitpack_pkg::word_w-1:0] mask2;    // 1 takes new bits, 0 keeps old
    logic                           sh2;
    logic                           c2;
    logic [bitpack_pkg::len_w-1:0]  n2;

    logic [d3_w-1:0]                data3;
    logic [bitpack_pkg::word_w-1:0] merged;
    logic [bitpack_pkg::word_w-1:0] acc;      // hold register, word being filled
    logic [bitpack_pkg::len_w-1:0]  pend;     // bits held in acc
    logic [bitpack_pkg::len_w:0]    pend_round;

    logic [bitpack_pkg::pack_dv_lat-1:0]    ds_stage;
    logic [bitpack_pkg::pack_flush_lat-2:0] flush_stage;
    logic merge_en;
    logic flush_done;

    assign pos_sum = {1'b0, pos} + {1'b0, dlen};
    assign merge_en = ds_stage[bitpack_pkg::pack_dv_lat-1];
    assign flush_done = flush_stage[bitpack_pkg::pack_flush_lat-2];

    // stage 3, last shift and merge with old bits
    assign data3 = {data2, 1'b0} >> sh2;
    assign merged = (acc & ~mask2) | (data3[d3_w-1 -: bitpack_pkg::word_w] & mask2);
    assign pend_round = {1'b0, pend} + (bitpack_pkg::len_w + 1)'(7);

    assign d_out = merge_en ? merged : acc;          // completed word or flushed tail
    assign dv = (merge_en && c2) || (flush_done && pend != '0);
    assign bytes_out = merge_en ? '0 : pend_round[bitpack_pkg::len_w-1 -: bitpack_pkg::cnt_w];

    always_ff @(posedge xclk) begin
        if (rst) begin
            pos <= '0;
            pend <= '0;
            ds_stage <= '0;
            flush_stage <= '0;
            flush_out <= 1'b0;
        end else begin
            ds_stage <= {ds_stage[bitpack_pkg::pack_dv_lat-2:0], ds};
            flush_stage <= {flush_stage[bitpack_pkg::pack_flush_lat-3:0], flush_in};
            flush_out <= flush_done;                 // one cycle after the tail word
            if (flush_in) begin
                pos <= '0;                           // next block starts a fresh word
            end else if (ds) begin
                pos <= pos_sum[bitpack_pkg::len_w-1:0];
            end
            if (flush_done) begin
                pend <= '0;
            end else if (merge_en) begin
                pend <= n2;
            end
        end
    end

    always_ff @(posedge xclk) begin
        // stage 1, coarse shift by whole bytes
        if (ds) begin
            data1 <= {din, {(bitpack_pkg::word_w-8){1'b0}}} >> {pos[bitpack_pkg::len_w-1:3], 3'b000};
            p1 <= pos;
            n1 <= pos_sum[bitpack_pkg::len_w-1:0];
            c1 <= pos_sum[bitpack_pkg::len_w];
        end
        // stage 2, shift by 0/2/4/6 and build the mask
        if (ds_stage[0]) begin
            data2 <= {data1, 6'b0} >> {p1[2:1], 1'b0};
            mask2 <= {bitpack_pkg::word_w{1'b1}} >> p1;
            sh2 <= p1[0];
            c2 <= c1;
            n2 <= n1;
        end
        // word done, spilled bits open the next one
        if (merge_en) begin
            acc <= c2 ? {data3[ov_w-1:0], {(bitpack_pkg::word_w-ov_w){1'b0}}} : merged;
        end
    end

endmodule

//--- design/bitpack_pkg.sv
// constants for packing variable-length codes into words
// code and length widths, packed word width, byte count width
// ds to dv and flush_in to flush_out pipeline depths of the packer
package bitpack_pkg;

    localparam int code_w = 27;          // widest code, MSB aligned
    localparam int len_w = 5;            // code length field, 1..27
    localparam int word_w = 32;          // packed output word
    localparam int cnt_w = 2;            // valid bytes in a word, 0 stands for 4

    localparam int pack_dv_lat = 2;      // ds to dv when the code completes a word
    localparam int pack_flush_lat = 4;   // flush_in to flush_out

endpackage

//--- design/byte_stuffer.sv
// byte serializer at the output of the buffer
// sends the valid bytes of each word, MSB first
// inserts 0x00 after every 0xFF data byte
// end entries become the 0xFF 0xD9 marker, out_last on 0xD9
`timescale 1ns/1ps

module byte_stuffer (
    input  logic                           xclk,
    input  logic                           rst,
    input  logic                           rd_valid,
    output logic                           rd_ready,
    input  logic [bitpack_pkg::word_w-1:0] rd_word,
    input  logic [bitpack_pkg::cnt_w-1:0]  rd_bytes,   // 0 means 4
    input  stream_pkg::entry_kind_e        rd_kind,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [7:0]                     out_byte,
    output logic                           out_last
);

    stream_pkg::stuff_state_e state;
    logic [bitpack_pkg::word_w-1:0] sh;     // bytes still to send, next at the top
    logic [bitpack_pkg::cnt_w-1:0]  left;   // bytes after the current one
    logic take;
    logic stuff;                            // current byte needs a zero behind it

    assign rd_ready = (state == stream_pkg::ST_IDLE);   // one entry at a time
    assign take = rd_valid && rd_ready;
    assign out_valid = (state != stream_pkg::ST_IDLE);
    assign out_last = (state == stream_pkg::ST_MARK_EOI);
    assign stuff = (state == stream_pkg::ST_DATA) && (out_byte == stream_pkg::marker_ff);

    always_ff @(posedge xclk) begin
        if (rst) begin
            state <= stream_pkg::ST_IDLE;
        end else begin
            case (state)
                stream_pkg::ST_IDLE: begin
                    if (take) begin
                        state <= (rd_kind == stream_pkg::ENTRY_END) ? stream_pkg::ST_MARK_FF
                                                                    : stream_pkg::ST_DATA;
                    end
                end
                stream_pkg::ST_DATA, stream_pkg::ST_ZERO: begin
                    if (out_ready) begin
                        if (stuff) state <= stream_pkg::ST_ZERO;
                        else if (left != '0) state <= stream_pkg::ST_DATA;
                        else state <= stream_pkg::ST_IDLE;          // word done
                    end
                end
                stream_pkg::ST_MARK_FF: begin
                    if (out_ready) state <= stream_pkg::ST_MARK_EOI;   // marker, no stuffing
                end
                stream_pkg::ST_MARK_EOI: begin
                    if (out_ready) state <= stream_pkg::ST_IDLE;
                end
                default: state <= stream_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (take) begin
            out_byte <= (rd_kind == stream_pkg::ENTRY_END) ? stream_pkg::marker_ff
                                                           : rd_word[bitpack_pkg::word_w-1 -: 8];
            sh <= rd_word << 8;
            left <= rd_bytes - 1'b1;                         // 0 wraps to 3 for a full word
        end else if (out_ready) begin
            case (state)
                stream_pkg::ST_DATA, stream_pkg::ST_ZERO: begin
                    if (stuff) begin
                        out_byte <= 8'h00;
                    end else if (left != '0) begin
                        out_byte <= sh[bitpack_pkg::word_w-1 -: 8];
                        sh <= sh << 8;
                        left <= left - 1'b1;
                    end
                end
                stream_pkg::ST_MARK_FF: out_byte <= stream_pkg::marker_eoi;
                default: out_byte <= out_byte;
            endcase
        end
    end

    a_out_hold: assert property (@(posedge xclk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_byte))
        else $error("out_byte changed while stalled");

endmodule

//--- design/code_emitter.sv
// code producer in front of the packer
// valid/ready input port gated by buffer room
// registers codes with the bits past their length cleared
// issues flush after the last code and waits for the packer to drain
`timescale 1ns/1ps

module code_emitter (
    input  logic                           xclk,
    input  logic                           rst,
    input  logic                           code_valid,
    output logic                           code_ready,
    input  logic [bitpack_pkg::code_w-1:0] code,
    input  logic [bitpack_pkg::len_w-1:0]  code_len,
    input  logic                           code_last,
    input  logic                           room,        // buffer has margin left
    input  logic                           flush_out,   // packer finished the block
    output logic                           ds,
    output logic [bitpack_pkg::code_w-1:0] din,
    output logic [bitpack_pkg::len_w-1:0]  dlen,
    output logic                           flush_in
);

    stream_pkg::emit_state_e state;
    logic accept;
    logic [bitpack_pkg::code_w-1:0] keep_mask;   // ones over the code_len top bits

    assign code_ready = (state == stream_pkg::EMIT_RUN) && room;
    assign accept = code_valid && code_ready;
    assign keep_mask = ~({bitpack_pkg::code_w{1'b1}} >> code_len);

    always_ff @(posedge xclk) begin
        if (rst) begin
            state <= stream_pkg::EMIT_RUN;
            ds <= 1'b0;
            flush_in <= 1'b0;
        end else begin
            ds <= accept;                                    // one strobe per code
            flush_in <= (state == stream_pkg::EMIT_FLUSH);   // right after the last ds
            case (state)
                stream_pkg::EMIT_RUN: begin
                    if (accept && code_last) state <= stream_pkg::EMIT_FLUSH;
                end
                stream_pkg::EMIT_FLUSH: state <= stream_pkg::EMIT_DRAIN;
                stream_pkg::EMIT_DRAIN: begin
                    if (flush_out) state <= stream_pkg::EMIT_RUN;   // block fully in buffer
                end
                default: state <= stream_pkg::EMIT_RUN;
            endcase
        end
    end

    // packer masks by position only, low bits must arrive clean
    always_ff @(posedge xclk) begin
        if (accept) begin
            din <= code & keep_mask;
            dlen <= code_len;
        end
    end

    a_len_nonzero: assert property (@(posedge xclk) disable iff (rst)
        accept |-> code_len != '0)
        else $error("code accepted with zero length");

endmodule

//--- design/entropy_out_top.sv
// output end of the entropy coder
// code emitter, bit packer, word buffer and byte stuffer in a chain
`timescale 1ns/1ps

module entropy_out_top (
    input  logic                           xclk,
    input  logic                           rst,
    input  logic                           code_valid,
    output logic                           code_ready,
    input  logic [bitpack_pkg::code_w-1:0] code,
    input  logic [bitpack_pkg::len_w-1:0]  code_len,
    input  logic                           code_last,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [7:0]                     out_byte,
    output logic                           out_last
);

    logic                           ds;          // emitter to packer
    logic [bitpack_pkg::code_w-1:0] din;
    logic [bitpack_pkg::len_w-1:0]  dlen;
    logic                           flush_in;
    logic                           dv;          // packer to buffer
    logic [bitpack_pkg::word_w-1:0] d_out;
    logic [bitpack_pkg::cnt_w-1:0]  bytes_out;
    logic                           flush_out;
    logic                           room;        // buffer back to emitter
    logic                           rd_valid;    // buffer to stuffer
    logic                           rd_ready;
    logic [bitpack_pkg::word_w-1:0] rd_word;
    logic [bitpack_pkg::cnt_w-1:0]  rd_bytes;
    stream_pkg::entry_kind_e        rd_kind;

    code_emitter i_emitter (
        .xclk       (xclk),
        .rst        (rst),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .code       (code),
        .code_len   (code_len),
        .code_last  (code_last),
        .room       (room),
        .flush_out  (flush_out),
        .ds         (ds),
        .din        (din),
        .dlen       (dlen),
        .flush_in   (flush_in)
    );

    bit_packer i_packer (
        .xclk      (xclk),
        .rst       (rst),
        .din       (din),
        .dlen      (dlen),
        .ds        (ds),
        .flush_in  (flush_in),
        .d_out     (d_out),
        .bytes_out (bytes_out),
        .dv        (dv),
        .flush_out (flush_out)
    );

    word_fifo i_fifo (
        .xclk      (xclk),
        .rst       (rst),
        .dv        (dv),
        .d_out     (d_out),
        .bytes_out (bytes_out),
        .flush_out (flush_out),
        .room      (room),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_word   (rd_word),
        .rd_bytes  (rd_bytes),
        .rd_kind   (rd_kind)
    );

    byte_stuffer i_stuffer (
        .xclk      (xclk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_word   (rd_word),
        .rd_bytes  (rd_bytes),
        .rd_kind   (rd_kind),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_byte  (out_byte),
        .out_last  (out_last)
    );

endmodule

//--- design/stream_pkg.sv
// constants and types for the buffered byte stream
// buffer depth and the free-entry margin for the emitter
// stuffing and end marker bytes
// buffer entry kinds, emitter and stuffer state encodings
package stream_pkg;

    localparam int fifo_depth = 16;             // buffer entries
    localparam int fifo_margin = 4;             // free entries needed to accept codes
    localparam logic [7:0] marker_ff = 8'hFF;   // stuffing trigger, marker prefix
    localparam logic [7:0] marker_eoi = 8'hD9;  // end of image code

    typedef enum logic {
        ENTRY_WORD,                             // packed data word
        ENTRY_END                               // block boundary, send end marker
    } entry_kind_e;

    typedef enum logic [1:0] {
        EMIT_RUN,
        EMIT_FLUSH,
        EMIT_DRAIN
    } emit_state_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DATA,
        ST_ZERO,
        ST_MARK_FF,
        ST_MARK_EOI
    } stuff_state_e;

endpackage

//--- design/word_fifo.sv
// circular buffer between packer and byte stuffer
// entries hold a word, its byte count and an entry kind tag
// room flag for the emitter, valid/ready read side
`timescale 1ns/1ps

module word_fifo (
    input  logic                           xclk,
    input  logic                           rst,
    input  logic                           dv,          // word entry write
    input  logic [bitpack_pkg::word_w-1:0] d_out,
    input  logic [bitpack_pkg::cnt_w-1:0]  bytes_out,
    input  logic                           flush_out,   // end entry write
    output logic                           room,
    output logic                           rd_valid,
    input  logic                           rd_ready,
    output logic [bitpack_pkg::word_w-1:0] rd_word,
    output logic [bitpack_pkg::cnt_w-1:0]  rd_bytes,
    output stream_pkg::entry_kind_e        rd_kind
);

    localparam int ptr_w = $clog2(stream_pkg::fifo_depth);

    logic [bitpack_pkg::word_w-1:0] mem_word [stream_pkg::fifo_depth];
    logic [bitpack_pkg::cnt_w-1:0]  mem_bytes [stream_pkg::fifo_depth];
    stream_pkg::entry_kind_e        mem_kind [stream_pkg::fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;      // entries held
    logic wr;
    logic rd;

    assign wr = dv || flush_out;
    assign rd = rd_valid && rd_ready;
    assign rd_valid = (count != '0);
    assign room = (count <= stream_pkg::fifo_depth - stream_pkg::fifo_margin);

    assign rd_word = mem_word[rd_ptr];
    assign rd_bytes = mem_bytes[rd_ptr];
    assign rd_kind = mem_kind[rd_ptr];

    always_ff @(posedge xclk) begin
        if (wr) begin
            mem_word[wr_ptr] <= d_out;                    // don't care for end entries
            mem_bytes[wr_ptr] <= bytes_out;
            mem_kind[wr_ptr] <= flush_out ? stream_pkg::ENTRY_END : stream_pkg::ENTRY_WORD;
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr) wr_ptr <= wr_ptr + 1'b1;              // depth is a power of two
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // packer has no stall, so the emitter margin must always cover it
    a_no_overflow: assert property (@(posedge xclk) disable iff (rst)
        wr |-> count < stream_pkg::fifo_depth)
        else $error("buffer written while full");

    a_no_collision: assert property (@(posedge xclk) disable iff (rst)
        !(dv && flush_out))
        else $error("dv and flush_out in the same cycle");

endmodule

//--- verification/tb_entropy_out.sv
// testbench for the entropy coder output end
// code table with fixed blocks and one long random block, applied in a loop
// bit level reference model builds the expected stuffed byte stream
// random out_ready from an LFSR, a forced stall window, cycle timeout
`timescale 1ns/1ps

module tb_entropy_out;

    localparam int fixed_n = 15;          // hand written entries
    localparam int rand_n = 64;           // random block, long enough to fill the buffer
    localparam int tab_n = fixed_n + rand_n;
    localparam int hold_cycles = 200;     // out_ready forced low this long
    localparam int stall_min = 20;        // blocked cycles expected during the hold

    logic                           xclk;
    logic                           rst;
    logic                           code_valid;
    logic                           code_ready;
    logic [bitpack_pkg::code_w-1:0] code;
    logic [bitpack_pkg::len_w-1:0]  code_len;
    logic                           code_last;
    logic                           out_valid;
    logic                           out_ready;
    logic [7:0]                     out_byte;
    logic                           out_last;

    // {last, len, value right aligned}
    logic [32:0] fixed_tab [fixed_n] = '{
        {1'b0, 5'd16, 27'hABCD},      // block of exactly one word
        {1'b1, 5'd16, 27'h1234},
        {1'b0, 5'd3,  27'h5},         // block of 23 bits, padded
        {1'b0, 5'd17, 27'h1A2B3},
        {1'b1, 5'd3,  27'h7},
        {1'b0, 5'd8,  27'hFF},        // 0xFF bytes, one built from two codes
        {1'b0, 5'd2,  27'h3},
        {1'b0, 5'd6,  27'h3F},
        {1'b0, 5'd4,  27'hF},
        {1'b1, 5'd4,  27'h0},
        {1'b0, 5'd27, 27'h7FFFFFF},   // all ones word, then one zero bit
        {1'b0, 5'd5,  27'h1F},
        {1'b1, 5'd1,  27'h0},
        {1'b1, 5'd1,  27'h1},         // single 1-bit blocks back to back
        {1'b1, 5'd1,  27'h0}
    };

    logic [26:0] tab_val [tab_n];
    logic [26:0] tab_junk [tab_n];        // garbage below the code length
    int          tab_len [tab_n];
    bit          tab_last [tab_n];

    logic [8:0]  exp_q [$];               // {last, byte}
    logic [15:0] lfsr = 16'd6;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 1_000_000;
    int          stall_cycles = 0;
    logic        hold_out = 1'b0;         // changes 1 ns after an edge
    logic        hold_q;                  // hold_out as seen at the edge
    logic [31:0] rnd;

    entropy_out_top i_dut (
        .xclk       (xclk),
        .rst        (rst),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .code       (code),
        .code_len   (code_len),
        .code_last  (code_last),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_byte   (out_byte),
        .out_last   (out_last)
    );

    always #10 xclk = ~xclk;              // 20 ns period

    // galois lfsr, taps 16,14,13,11
    function logic next_rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_value(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[30:0], next_rand_bit()};
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic build_table();
        int len;
        for (int i = 0; i < fixed_n; i++) begin
            tab_last[i] = fixed_tab[i][32];
            tab_len[i] = fixed_tab[i][31:27];
            tab_val[i] = fixed_tab[i][26:0];
        end
        for (int i = fixed_n; i < tab_n; i++) begin
            len = rand_value(5) % 27 + 1;
            tab_len[i] = len;
            tab_val[i] = rand_value(27) & ((32'd1 << len) - 1);
            tab_last[i] = (i == tab_n - 1);          // whole random part is one block
        end
        for (int i = 0; i < tab_n; i++) begin
            tab_junk[i] = rand_value(27) & ((32'd1 << (27 - tab_len[i])) - 1);
        end
    endtask

    // concatenate code bits, pad each block to a byte, stuff, add the marker
    task automatic build_expected();
        bit bits [$];
        logic [8:0] b;
        for (int i = 0; i < tab_n; i++) begin
            for (int k = tab_len[i] - 1; k >= 0; k--) bits.push_back(tab_val[i][k]);
            if (tab_last[i]) begin
                while (bits.size() % 8 != 0) bits.push_back(1'b0);
                while (bits.size() != 0) begin
                    b = 9'h000;
                    for (int k = 7; k >= 0; k--) b[k] = bits.pop_front();
                    exp_q.push_back(b);
                    if (b[7:0] == 8'hFF) exp_q.push_back(9'h000);
                end
                exp_q.push_back({1'b0, 8'hFF});
                exp_q.push_back({1'b1, 8'hD9});     // end marker is never stuffed
            end
        end
    endtask

    // output side, ready three times out of four unless held
    always @(posedge xclk) begin
        hold_q = hold_out;
        #1;
        rnd = rand_value(2);
        out_ready = hold_q ? 1'b0 : (rnd[1:0] != 2'b00);
    end

    always @(posedge xclk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected output byte 0x%02h after the expected stream ended", out_byte);
            end else begin
                check_value("out_byte", out_byte, exp_q[0][7:0]);
                check_value("out_last", out_last, exp_q[0][8]);
                void'(exp_q.pop_front());
            end
        end
        if (hold_out && code_valid && !code_ready) stall_cycles++;   // producer blocked
    end

    always @(posedge xclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d bytes still expected",
                     cycles, exp_q.size());
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // end the stall window a fixed time after it starts
    initial begin
        wait (hold_out);
        repeat (hold_cycles) @(posedge xclk);
        #1 hold_out = 1'b0;
    end

    initial begin
        xclk = 1'b0;
        rst = 1'b1;
        code_valid = 1'b0;
        code = '0;
        code_len = '0;
        code_last = 1'b0;
        out_ready = 1'b0;
        build_table();
        build_expected();
        cycle_limit = 1000 + hold_cycles + 10 * tab_n + 12 * exp_q.size();
        repeat (8) @(posedge xclk);
        #1 rst = 1'b0;
        check_value("code_ready", code_ready, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_last", out_last, 1'b0);
        for (int i = 0; i < tab_n; i++) begin
            if (i == fixed_n) hold_out = 1'b1;      // stall output for the long block
            code_valid = 1'b1;
            code = (tab_val[i] << (27 - tab_len[i])) | tab_junk[i];
            code_len = tab_len[i];
            code_last = tab_last[i];
            @(posedge xclk);
            while (!code_ready) @(posedge xclk);
            #1;
        end
        code_valid = 1'b0;
        code_last = 1'b0;
        while (exp_q.size() != 0) @(negedge xclk);
        repeat (20) @(posedge xclk);                // catch extra bytes
        if (stall_cycles < stall_min) begin
            errors++;
            $display("code_ready did not drop while the output was stalled (%0d cycles)",
                     stall_cycles);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
